// ==== Makefile ====
TOP = tb_flit_queue

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

obj_dir/V$(TOP): project.f $(wildcard common/* flit_queue/* tb/*)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== common/fq_params.svh ====
`ifndef FQ_PARAMS_SVH
`define FQ_PARAMS_SVH

// Timestamp and global simulation time
`define FQ_TS_WIDTH 16

// Link latency held by the configuration chain
`define FQ_LAT_WIDTH 8

// Configuration chain word
`define FQ_CFG_WIDTH 16

// Virtual channels
`define FQ_LOG_NVCS 1
`define FQ_NVCS (1 << `FQ_LOG_NVCS)

// Queue id and opaque payload
`define FQ_ID_WIDTH 3
`define FQ_PAYLOAD_WIDTH 12

// Per-VC queue depth
`define FQ_LOG_DEP 3
`define FQ_DEPTH (1 << `FQ_LOG_DEP)

`endif

// ==== common/fq_pkg.sv ====
`include "fq_params.svh"

package fq_pkg;

    typedef logic [`FQ_TS_WIDTH-1:0] ts_t;
    typedef logic [`FQ_LAT_WIDTH-1:0] lat_t;
    typedef logic [`FQ_LOG_NVCS-1:0] vc_t;
    typedef logic [`FQ_ID_WIDTH-1:0] id_t;

    // 32-bit flit, timestamp in the top bits
    typedef struct packed {
        ts_t                           ts;
        vc_t                           vc;
        id_t                           src;
        logic [`FQ_PAYLOAD_WIDTH-1:0]  payload;
    } flit_t;

    // Advance the timestamp by the link latency, wrapping at 16 bits
    function automatic flit_t stamp_flit(flit_t f, lat_t lat);
        flit_t r;
        r = f;
        r.ts = f.ts + ts_t'(lat);
        return r;
    endfunction

    // True once now has reached ts, tolerant of counter wrap
    function automatic logic ts_reached(ts_t ts, ts_t now);
        ts_t diff;
        diff = now - ts;
        return !diff[`FQ_TS_WIDTH-1];
    endfunction

endpackage

// ==== flit_queue/flit_queue.sv ====
`include "fq_params.svh"

module flit_queue
    import fq_pkg::*;
#(
    parameter id_t queue_id = id_t'(1)
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     enable,
    input  ts_t                      sim_time,
    output logic                     error,
    output logic                     is_quiescent,
    output lat_t                     latency,
    input  logic [`FQ_CFG_WIDTH-1:0] config_in,
    input  logic                     config_in_valid,
    output logic [`FQ_CFG_WIDTH-1:0] config_out,
    output logic                     config_out_valid,
    output logic [`FQ_NVCS-1:0]      flit_full,
    input  logic                     flit_in_valid,
    input  flit_t                    flit_in,
    input  id_t                      nexthop_in,
    output logic                     flit_ack,
    output flit_t [`FQ_NVCS-1:0]     flit_out,
    output logic [`FQ_NVCS-1:0]      flit_out_valid,
    input  logic [`FQ_NVCS-1:0]      dequeue
);

    flit_t               flit_stamped;
    flit_t               ram_data;
    logic                hop_match;
    logic                ram_read;
    vc_t                 ram_read_vc;
    logic [`FQ_NVCS-1:0] vc_has_data;
    logic [`FQ_NVCS-1:0] vc_empty;
    logic [`FQ_NVCS-1:0] vc_pop;
    logic                heads_empty;

    // Only flits routed to this queue are taken
    assign hop_match = flit_in_valid && enable && (nexthop_in == queue_id);
    assign flit_ack  = hop_match && !flit_full[flit_in.vc];

    assign is_quiescent = &vc_empty && heads_empty;

    fq_ctrl u_ctrl (
        .clock            (clock),
        .rst_n            (rst_n),
        .config_in        (config_in),
        .config_in_valid  (config_in_valid),
        .flit_in          (flit_in),
        .config_out       (config_out),
        .config_out_valid (config_out_valid),
        .flit_stamped     (flit_stamped),
        .latency          (latency)
    );

    vc_ram_fifo u_fifo (
        .clock    (clock),
        .rst_n    (rst_n),
        .enable   (enable),
        .write    (flit_ack),
        .data_in  (flit_stamped),
        .read     (ram_read),
        .read_vc  (ram_read_vc),
        .pop      (vc_pop),
        .data_out (ram_data),
        .has_data (vc_has_data),
        .full     (flit_full),
        .empty    (vc_empty)
    );

    vc_out_stage u_out (
        .clock          (clock),
        .rst_n          (rst_n),
        .enable         (enable),
        .sim_time       (sim_time),
        .has_data       (vc_has_data),
        .data_in        (ram_data),
        .dequeue        (dequeue),
        .read           (ram_read),
        .read_vc        (ram_read_vc),
        .pop            (vc_pop),
        .flit_out       (flit_out),
        .flit_out_valid (flit_out_valid),
        .error          (error),
        .heads_empty    (heads_empty)
    );

endmodule

// ==== flit_queue/fq_ctrl.sv ====
`include "fq_params.svh"

module fq_ctrl
    import fq_pkg::*;
(
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic [`FQ_CFG_WIDTH-1:0] config_in,
    input  logic                     config_in_valid,
    input  flit_t                    flit_in,
    output logic [`FQ_CFG_WIDTH-1:0] config_out,
    output logic                     config_out_valid,
    output flit_t                    flit_stamped,
    output lat_t                     latency
);

    // Latency register and the valid bit of the chain output stage
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            latency          <= '0;
            config_out_valid <= 1'b0;
        end
        else
        begin
            config_out_valid <= config_in_valid;
            if (config_in_valid)
            begin
                latency <= config_in[`FQ_LAT_WIDTH-1:0];
            end
        end
    end

    // Old latency is shifted on down the chain
    always_ff @(posedge clock)
    begin
        if (config_in_valid)
        begin
            config_out <= `FQ_CFG_WIDTH'(latency);
        end
    end

    assign flit_stamped = stamp_flit(flit_in, latency);

endmodule

// ==== flit_queue/vc_out_stage.sv ====
`include "fq_params.svh"

module vc_out_stage
    import fq_pkg::*;
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       enable,
    input  ts_t                        sim_time,
    input  logic [`FQ_NVCS-1:0]        has_data,
    input  flit_t                      data_in,
    input  logic [`FQ_NVCS-1:0]        dequeue,
    output logic                       read,
    output vc_t                        read_vc,
    output logic [`FQ_NVCS-1:0]        pop,
    output flit_t [`FQ_NVCS-1:0]       flit_out,
    output logic [`FQ_NVCS-1:0]        flit_out_valid,
    output logic                       error,
    output logic                       heads_empty
);

    localparam int NVCS = `FQ_NVCS;

    flit_t [NVCS-1:0] head;
    logic [NVCS-1:0]  head_valid;
    logic [NVCS-1:0]  inflight;
    logic [NVCS-1:0]  eligible;
    logic [NVCS-1:0]  load;
    logic             rd_pend;
    vc_t              rd_vc_q;
    vc_t              rr_last;

    assign eligible = enable ? (has_data & ~head_valid & ~inflight) : '0;

    // Round-robin pick, starting after the last VC served
    always_comb
    begin
        vc_t cand;
        read    = 1'b0;
        read_vc = rr_last;
        for (int k = 1; k <= NVCS; k++)
        begin
            cand = rr_last + vc_t'(k);
            if (!read && eligible[cand])
            begin
                read    = 1'b1;
                read_vc = cand;
            end
        end
    end

    for (genvar i = 0; i < NVCS; i++)
    begin : g_head
        assign load[i]           = rd_pend && (rd_vc_q == vc_t'(i));
        assign flit_out_valid[i] = head_valid[i] && ts_reached(head[i].ts, sim_time);
        assign pop[i]            = enable && dequeue[i] && flit_out_valid[i];
        assign flit_out[i]       = head[i];

        always_ff @(posedge clock)
        begin
            if (load[i])
            begin
                head[i] <= data_in;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            head_valid <= '0;
            inflight   <= '0;
            rd_pend    <= 1'b0;
            rd_vc_q    <= '0;
            rr_last    <= '0;
            error      <= 1'b0;
        end
        else
        begin
            rd_pend <= read;
            if (read)
            begin
                rd_vc_q <= read_vc;
                rr_last <= read_vc;
            end
            // Load and pop never hit the same VC in one cycle
            head_valid <= (head_valid | load) & ~pop;
            inflight   <= (inflight & ~load) | (read ? (NVCS'(1) << read_vc) : '0);
            if (|(dequeue & ~flit_out_valid))
            begin
                error <= 1'b1;
            end
        end
    end

    assign heads_empty = ~|head_valid && ~|inflight;

endmodule

// ==== flit_queue/vc_ram_fifo.sv ====
`include "fq_params.svh"

module vc_ram_fifo
    import fq_pkg::*;
(
    input  logic                clock,
    input  logic                rst_n,
    input  logic                enable,
    input  logic                write,
    input  flit_t               data_in,
    input  logic                read,
    input  vc_t                 read_vc,
    input  logic [`FQ_NVCS-1:0] pop,
    output flit_t               data_out,
    output logic [`FQ_NVCS-1:0] has_data,
    output logic [`FQ_NVCS-1:0] full,
    output logic [`FQ_NVCS-1:0] empty
);

    localparam int NVCS     = `FQ_NVCS;
    localparam int LOG_NVCS = `FQ_LOG_NVCS;
    localparam int LOG_DEP  = `FQ_LOG_DEP;
    localparam int DEPTH    = `FQ_DEPTH;
    localparam int CNT_W    = LOG_DEP + 1;

    flit_t mem [NVCS*DEPTH];

    logic [LOG_DEP-1:0]          wptr [NVCS];
    logic [LOG_DEP-1:0]          rptr [NVCS];
    logic [CNT_W-1:0]            used [NVCS];
    logic [CNT_W-1:0]            unread [NVCS];
    logic [LOG_NVCS+LOG_DEP-1:0] waddr;
    logic [LOG_NVCS+LOG_DEP-1:0] raddr;
    logic                        wr_en;
    logic                        rd_en;

    assign wr_en = enable && write;
    assign rd_en = enable && read;

    // Context bits on top, pointer below
    assign waddr = {data_in.vc, wptr[data_in.vc]};
    assign raddr = {read_vc, rptr[read_vc]};

    always_ff @(posedge clock)
    begin
        if (wr_en)
        begin
            mem[waddr] <= data_in;
        end
        if (rd_en)
        begin
            data_out <= mem[raddr];
        end
    end

    for (genvar i = 0; i < NVCS; i++)
    begin : g_ctx
        logic wr_hit;
        logic rd_hit;
        logic pop_hit;

        assign wr_hit  = wr_en && (data_in.vc == vc_t'(i));
        assign rd_hit  = rd_en && (read_vc == vc_t'(i));
        assign pop_hit = enable && pop[i];

        always_ff @(posedge clock or negedge rst_n)
        begin
            if (!rst_n)
            begin
                wptr[i]   <= '0;
                rptr[i]   <= '0;
                used[i]   <= '0;
                unread[i] <= '0;
            end
            else
            begin
                if (wr_hit)
                begin
                    wptr[i] <= wptr[i] + 1'b1;
                end
                if (rd_hit)
                begin
                    rptr[i] <= rptr[i] + 1'b1;
                end
                // Occupancy lasts until the head is popped downstream
                case ({wr_hit, pop_hit})
                    2'b10:   used[i] <= used[i] + 1'b1;
                    2'b01:   used[i] <= used[i] - 1'b1;
                    default: used[i] <= used[i];
                endcase
                case ({wr_hit, rd_hit})
                    2'b10:   unread[i] <= unread[i] + 1'b1;
                    2'b01:   unread[i] <= unread[i] - 1'b1;
                    default: unread[i] <= unread[i];
                endcase
            end
        end

        assign has_data[i] = (unread[i] != '0);
        assign full[i]     = (used[i] == CNT_W'(DEPTH));
        assign empty[i]    = (used[i] == '0);
    end

endmodule

// ==== project.f ====
+incdir+common
common/fq_pkg.sv
flit_queue/fq_ctrl.sv
flit_queue/vc_ram_fifo.sv
flit_queue/vc_out_stage.sv
flit_queue/flit_queue.sv
tb/tb_flit_queue.sv

// ==== tb/tb_flit_queue.sv ====
`include "fq_params.svh"

module tb_flit_queue
    import fq_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NVCS = `FQ_NVCS;
    localparam int DEPTH = `FQ_DEPTH;
    localparam id_t QUEUE_ID = id_t'(1);
    localparam int CYCLE_LIMIT = 3000;

    logic clock = 1'b0;
    logic rst_n;
    logic enable;
    ts_t sim_time = '0;
    logic error;
    logic is_quiescent;
    lat_t latency;
    logic [`FQ_CFG_WIDTH-1:0] config_in;
    logic config_in_valid;
    logic [`FQ_CFG_WIDTH-1:0] config_out;
    logic config_out_valid;
    logic [NVCS-1:0] flit_full;
    logic flit_in_valid;
    flit_t flit_in;
    id_t nexthop_in;
    logic flit_ack;
    flit_t [NVCS-1:0] flit_out;
    logic [NVCS-1:0] flit_out_valid;
    logic [NVCS-1:0] dequeue = '0;

    // Reference model state
    flit_t exp_q [NVCS][$];
    flit_t exp_head [NVCS];
    int model_count [NVCS];
    lat_t model_lat;
    logic [`FQ_CFG_WIDTH-1:0] exp_cfg_out;
    logic exp_cfg_valid;
    logic exp_error;
    logic exp_ack;
    logic model_idle;

    logic drain_en;
    logic bad_deq;
    integer seed = 32'h9972_0666;
    int cycle_count = 0;
    int fail_count = 0;
    int fails_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    string test_name = "reset";

    flit_queue #(
        .queue_id (QUEUE_ID)
    ) dut (
        .clock            (clock),
        .rst_n            (rst_n),
        .enable           (enable),
        .sim_time         (sim_time),
        .error            (error),
        .is_quiescent     (is_quiescent),
        .latency          (latency),
        .config_in        (config_in),
        .config_in_valid  (config_in_valid),
        .config_out       (config_out),
        .config_out_valid (config_out_valid),
        .flit_full        (flit_full),
        .flit_in_valid    (flit_in_valid),
        .flit_in          (flit_in),
        .nexthop_in       (nexthop_in),
        .flit_ack         (flit_ack),
        .flit_out         (flit_out),
        .flit_out_valid   (flit_out_valid),
        .dequeue          (dequeue)
    );

    always #10 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        sim_time    <= sim_time + ts_t'(1);
    end

    // Accept rule, using the model's own occupancy
    always_comb
    begin
        exp_ack = flit_in_valid && enable && (nexthop_in == QUEUE_ID)
                  && (model_count[flit_in.vc] != DEPTH);
        model_idle = 1'b1;
        for (int v = 0; v < NVCS; v++)
        begin
            if (model_count[v] != 0)
            begin
                model_idle = 1'b0;
            end
        end
    end

    always @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int v = 0; v < NVCS; v++)
            begin
                exp_q[v].delete();
                model_count[v] <= 0;
                exp_head[v]    <= '0;
            end
            model_lat     <= '0;
            exp_cfg_out   <= '0;
            exp_cfg_valid <= 1'b0;
            exp_error     <= 1'b0;
        end
        else
        begin
            exp_cfg_valid <= config_in_valid;
            if (config_in_valid)
            begin
                exp_cfg_out <= `FQ_CFG_WIDTH'(model_lat);
                model_lat   <= config_in[`FQ_LAT_WIDTH-1:0];
            end
            if (|(dequeue & ~flit_out_valid))
            begin
                exp_error <= 1'b1;
            end
            for (int v = 0; v < NVCS; v++)
            begin
                if (enable && dequeue[v] && flit_out_valid[v])
                begin
                    void'(exp_q[v].pop_front());
                end
            end
            if (exp_ack)
            begin
                exp_q[flit_in.vc].push_back(stamp_flit(flit_in, model_lat));
            end
            for (int v = 0; v < NVCS; v++)
            begin
                model_count[v] <= exp_q[v].size();
                if (exp_q[v].size() != 0)
                begin
                    exp_head[v] <= exp_q[v][0];
                end
            end
        end
    end

    // Sink pops a released head, never two cycles running on one VC
    always @(posedge clock)
    begin
        logic [NVCS-1:0] next;
        next = drain_en ? (flit_out_valid & ~dequeue) : '0;
        next[0] = next[0] | bad_deq;
        if (!rst_n)
        begin
            dequeue <= '0;
        end
        else
        begin
            dequeue <= next;
        end
    end

    task automatic report_mismatch(input string check, input logic [31:0] expected,
                                   input logic [31:0] actual);
        fail_count++;
        $display("CHECK FAILED %s (%s): expected %h, actual %h", test_name, check,
                 expected, actual);
    endtask

    task automatic report_problem(input string text);
        fail_count++;
        $display("ERROR in %s: %s", test_name, text);
    endtask

    a_latency: assert property (@(posedge clock) disable iff (!rst_n) latency == model_lat)
        else report_mismatch("latency", 32'($sampled(model_lat)), 32'($sampled(latency)));
    a_cfg_valid: assert property (@(posedge clock) disable iff (!rst_n)
        config_out_valid == exp_cfg_valid)
        else report_mismatch("config_out_valid", 32'($sampled(exp_cfg_valid)),
                             32'($sampled(config_out_valid)));
    a_cfg_out: assert property (@(posedge clock) disable iff (!rst_n)
        config_out_valid |-> config_out == exp_cfg_out)
        else report_mismatch("config_out", 32'($sampled(exp_cfg_out)),
                             32'($sampled(config_out)));
    a_ack: assert property (@(posedge clock) disable iff (!rst_n) flit_ack == exp_ack)
        else report_mismatch("flit_ack", 32'($sampled(exp_ack)), 32'($sampled(flit_ack)));
    a_error: assert property (@(posedge clock) disable iff (!rst_n) error == exp_error)
        else report_mismatch("error", 32'($sampled(exp_error)), 32'($sampled(error)));
    a_quiet: assert property (@(posedge clock) disable iff (!rst_n) is_quiescent == model_idle)
        else report_mismatch("is_quiescent", 32'($sampled(model_idle)),
                             32'($sampled(is_quiescent)));

    for (genvar i = 0; i < NVCS; i++)
    begin : g_vc_checks
        a_full: assert property (@(posedge clock) disable iff (!rst_n)
            flit_full[i] == (model_count[i] == DEPTH))
            else report_mismatch("flit_full", 32'($sampled(model_count[i] == DEPTH)),
                                 32'($sampled(flit_full[i])));
        a_known: assert property (@(posedge clock) disable iff (!rst_n)
            flit_out_valid[i] |-> model_count[i] != 0)
            else report_problem("a flit was offered that was never accepted");
        a_value: assert property (@(posedge clock) disable iff (!rst_n)
            flit_out_valid[i] |-> flit_out[i] == exp_head[i])
            else report_mismatch("flit_out", $sampled(exp_head[i]), $sampled(flit_out[i]));
        // Head may not show before its stamped time
        a_time: assert property (@(posedge clock) disable iff (!rst_n)
            flit_out_valid[i] |-> sim_time >= flit_out[i].ts)
            else report_mismatch("release time", 32'($sampled(flit_out[i].ts)),
                                 32'($sampled(sim_time)));
    end

    task automatic write_config(input logic [`FQ_CFG_WIDTH-1:0] word);
        @(posedge clock);
        config_in       <= word;
        config_in_valid <= 1'b1;
    endtask

    task automatic idle_config();
        @(posedge clock);
        config_in_valid <= 1'b0;
    endtask

    task automatic offer_flit(input vc_t vc, input id_t hop);
        flit_t f;
        logic [31:0] rnd;
        rnd = $random(seed);
        f.ts = sim_time;
        f.vc = vc;
        f.src = rnd[2:0];
        f.payload = rnd[14:3];
        @(posedge clock);
        flit_in       <= f;
        nexthop_in    <= hop;
        flit_in_valid <= 1'b1;
    endtask

    task automatic idle_input();
        @(posedge clock);
        flit_in_valid <= 1'b0;
    endtask

    task automatic wait_quiet(input int limit);
        int n;
        n = 0;
        repeat (2) @(posedge clock);
        while (!model_idle && n < limit)
        begin
            @(posedge clock);
            n++;
        end
        if (!model_idle)
        begin
            report_problem("accepted flits were not all delivered in time");
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        fails_at_start = fail_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (fail_count > fails_at_start)
        begin
            tests_failed++;
        end
        $display("test %-14s %s", test_name, (fail_count > fails_at_start) ? "FAIL" : "ok");
    endtask

    initial
    begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        logic [31:0] rnd;
        rst_n = 1'b0;
        enable = 1'b0;
        config_in = '0;
        config_in_valid = 1'b0;
        flit_in_valid = 1'b0;
        flit_in = '0;
        nexthop_in = '0;
        drain_en = 1'b1;
        bad_deq = 1'b0;
        repeat (16) @(posedge clock);
        rst_n  <= 1'b1;
        enable <= 1'b1;
        repeat (2) @(posedge clock);

        start_test("config_chain");
        write_config(16'h0105);
        write_config(16'h0a33);
        write_config(16'hbe04);
        idle_config();
        repeat (2) @(posedge clock);
        if (latency !== 8'h04)
        begin
            report_mismatch("final latency", 32'h04, 32'(latency));
        end
        end_test();

        start_test("stamping");
        for (int k = 0; k < 10; k++)
        begin
            rnd = $random(seed);
            offer_flit(vc_t'(rnd[5]), QUEUE_ID);
        end
        idle_input();
        wait_quiet(200);
        end_test();

        start_test("nexthop_filter");
        for (int k = 0; k < 12; k++)
        begin
            rnd = $random(seed);
            offer_flit(vc_t'(rnd[7]), (k % 3 == 0) ? QUEUE_ID : (QUEUE_ID ^ (rnd[2:0] | 3'd1)));
        end
        idle_input();
        wait_quiet(200);
        end_test();

        start_test("timed_release");
        write_config(16'h00c8);
        idle_config();
        repeat (2) @(posedge clock);
        offer_flit(vc_t'(1), QUEUE_ID);
        idle_input();
        wait_quiet(400);
        write_config(16'h0002);
        idle_config();
        end_test();

        start_test("back_pressure");
        drain_en <= 1'b0;
        for (int k = 0; k < 10; k++)
        begin
            offer_flit(vc_t'(0), QUEUE_ID);
        end
        idle_input();
        @(posedge clock);
        if (flit_full[0] !== 1'b1)
        begin
            report_mismatch("vc0 full", 32'h1, 32'(flit_full[0]));
        end
        for (int k = 0; k < 3; k++)
        begin
            offer_flit(vc_t'(1), QUEUE_ID);
        end
        idle_input();
        drain_en <= 1'b1;
        wait_quiet(300);
        end_test();

        start_test("error_quiet");
        @(posedge clock);
        bad_deq <= 1'b1;
        @(posedge clock);
        bad_deq <= 1'b0;
        repeat (4) @(posedge clock);
        if (error !== 1'b1)
        begin
            report_mismatch("sticky error", 32'h1, 32'(error));
        end
        offer_flit(vc_t'(0), QUEUE_ID);
        offer_flit(vc_t'(1), QUEUE_ID);
        idle_input();
        wait_quiet(200);
        @(posedge clock);
        if (is_quiescent !== 1'b1)
        begin
            report_mismatch("final quiescence", 32'h1, 32'(is_quiescent));
        end
        end_test();

        $display("%0d tests run, %0d tests failed, %0d failed checks",
                 tests_run, tests_failed, fail_count);
        if (fail_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
